// File: Bender.yml
package:
  name: demoscene

sources:
  - files:
      - design/demo_pkg.sv
      - design/demo_cfg_if.sv
      - design/vga_timing.sv
      - design/bitmap_rom.sv
      - design/box_animator.sv
      - design/demo_regs.sv
      - design/pixel_mixer.sv
      - design/demoscene_top.sv
  - target: simulation
    files:
      - sim/tb_clkgen.sv
      - sim/demoscene_tb.sv

// File: demoscene.f
design/demo_pkg.sv
design/demo_cfg_if.sv
design/vga_timing.sv
design/bitmap_rom.sv
design/box_animator.sv
design/demo_regs.sv
design/pixel_mixer.sv
design/demoscene_top.sv
sim/tb_clkgen.sv
sim/demoscene_tb.sv

// File: design/bitmap_rom.sv
`timescale 1ns/1ps
`default_nettype none

module bitmap_rom (
  input  logic        clk,
  input  logic        rst_n,
  input  logic [4:0]  row_sel,
  output logic [31:0] row_bits
);

  logic [31:0] row_data;

  // Bit 31 is the leftmost cell
  always_comb
  begin
    case (row_sel)
      5'd0:    row_data = 32'h2E7C_A180;
      5'd1:    row_data = 32'h5108_A240;
      5'd2:    row_data = 32'hF108_A240;
      5'd3:    row_data = 32'h9108_E240;
      5'd4:    row_data = 32'h9E08_A180;
      5'd6:    row_data = 32'hE39C_F7C0;
      5'd7:    row_data = 32'h9420_8100;
      5'd8:    row_data = 32'h9418_E100;
      5'd9:    row_data = 32'h9404_8100;
      5'd10:   row_data = 32'hE338_F100;
      5'd12:   row_data = 32'h0FFF_FFF0;   // Frame around the wave
      5'd13:   row_data = 32'h1000_0008;
      5'd14:   row_data = 32'h2492_4924;
      5'd15:   row_data = 32'h4924_9242;
      5'd16:   row_data = 32'h2492_4924;
      5'd17:   row_data = 32'h1000_0008;
      5'd18:   row_data = 32'h0FFF_FFF0;
      5'd20:   row_data = 32'h0181_8180;
      5'd21:   row_data = 32'h03C3_C3C0;
      5'd22:   row_data = 32'h07E7_E7E0;
      5'd23:   row_data = 32'h0FFF_FFF0;
      5'd24:   row_data = 32'h07E7_E7E0;
      5'd25:   row_data = 32'h03C3_C3C0;
      5'd26:   row_data = 32'h0181_8180;
      5'd28:   row_data = 32'hFFFF_FFFF;   // Underline
      default: row_data = 32'h0000_0000;   // Spacer rows and rows 29 to 31
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      row_bits <= '0;
    else
      row_bits <= row_data;
  end

endmodule

`default_nettype wire

// File: design/box_animator.sv
`timescale 1ns/1ps
`default_nettype none

module box_animator
  import demo_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  demo_cfg_if.anim    cfg,
  input  logic [9:0]  hpos,
  input  logic [9:0]  vpos,
  input  logic        frame_start,
  output logic [9:0]  offset,
  output logic [15:0] frame_count,
  output logic        red_win,
  output logic        green_win,
  output logic        blue_win
);

  dir_t dir;

  // Signed copies so the bounds may go below zero
  logic signed [13:0] h;
  logic signed [13:0] v;
  logic signed [13:0] off;
  logic red_hit;
  logic green_hit;
  logic blue_hit;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      offset      <= '0;
      dir         <= up;
      frame_count <= '0;
    end
    else if (frame_start)
    begin
      frame_count <= frame_count + 16'd1;
      if (cfg.anim_en)
      begin
        case (dir)
          up:
          begin
            if (offset < cfg.offset_limit)
              offset <= offset + 10'd1;
            else
            begin
              dir <= down;
              if (offset != '0)
                offset <= offset - 10'd1;
            end
          end
          down:
          begin
            if (offset != '0)
              offset <= offset - 10'd1;
            else
            begin
              dir <= up;
              if (cfg.offset_limit != '0)
                offset <= offset + 10'd1;
            end
          end
          default: dir <= up;
        endcase
      end
    end
  end

  assign h   = signed'({4'd0, hpos});
  assign v   = signed'({4'd0, vpos});
  assign off = signed'({4'd0, offset});

  always_comb
  begin
    red_hit   = (h > box_h_min - off) && (h < box_h_max + off) &&
                (v > box_v_min - off) && (v < box_v_max + off);
    // Narrower, and stretched downwards
    green_hit = (h > box_h_min - off + box_inset) && (h < box_h_max + off - box_inset) &&
                (v > box_v_min - (off >>> 1)) && (v < box_v_max + off * 3);
    blue_hit  = (h - off * 2 > box_h_min - off) && (h - off * 2 < box_h_max + off) &&
                (v - off * 2 > box_v_min - off) && (v - off * 2 < box_v_max + off);
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      red_win   <= 1'b0;
      green_win <= 1'b0;
      blue_win  <= 1'b0;
    end
    else
    begin
      red_win   <= red_hit;
      green_win <= green_hit;
      blue_win  <= blue_hit;
    end
  end

endmodule

`default_nettype wire

// File: design/demo_cfg_if.sv
`timescale 1ns/1ps
`default_nettype none

// Static picture settings from the register block
interface demo_cfg_if;

  logic       box_en;
  logic       bmp_en;
  logic       anim_en;
  logic [5:0] bmp_color;     // {r, g, b} two bits each
  logic [9:0] offset_limit;

  modport regs (output box_en, bmp_en, anim_en, bmp_color, offset_limit);

  modport anim (input anim_en, offset_limit);

  modport mix (input box_en, bmp_en, bmp_color);

endinterface

`default_nettype wire

// File: design/demo_pkg.sv
`default_nettype none

package demo_pkg;

  // 640x480 at 60 Hz, one pixel per clock
  localparam int h_visible = 640;
  localparam int h_front   = 16;
  localparam int h_sync    = 96;
  localparam int h_back    = 48;
  localparam int h_total   = 800;

  localparam int v_visible = 480;
  localparam int v_front   = 10;
  localparam int v_sync    = 2;
  localparam int v_back    = 33;
  localparam int v_total   = 525;

  // Centre rectangle bounds
  localparam int box_h_min = 300;
  localparam int box_h_max = 340;
  localparam int box_v_min = 210;
  localparam int box_v_max = 250;
  localparam int box_inset = 15;   // Green box horizontal narrowing

  localparam int bmp_x_limit = 510;
  localparam int bmp_y_limit = 500;

  localparam logic [3:0] addr_ctrl   = 4'h0;
  localparam logic [3:0] addr_color  = 4'h4;
  localparam logic [3:0] addr_limit  = 4'h8;
  localparam logic [3:0] addr_status = 4'hC;

  // CTRL bit positions
  localparam int ctrl_box_bit  = 0;
  localparam int ctrl_bmp_bit  = 1;
  localparam int ctrl_anim_bit = 2;

  localparam logic [2:0] ctrl_reset  = 3'b111;  // Boxes, logo, animation on
  localparam logic [5:0] color_reset = 6'h3F;   // White logo
  localparam logic [9:0] limit_reset = 10'd200;

  typedef enum logic {up, down} dir_t;

  typedef enum logic [1:0] {apb_idle, apb_setup, apb_access} apb_state_t;

endpackage

`default_nettype wire

// File: design/demo_regs.sv
`timescale 1ns/1ps
`default_nettype none

module demo_regs
  import demo_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [3:0]  paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr,
  demo_cfg_if.regs    cfg,
  input  logic [9:0]  offset,
  input  logic [15:0] frame_count
);

  apb_state_t  state;   // Bus phase of the previous clock
  logic [2:0]  ctrl;
  logic [5:0]  color;
  logic [9:0]  limit;
  logic        access;
  logic        rd_hit;
  logic        wr_hit;
  logic [31:0] rd_data;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      state <= apb_idle;
    else if (!psel)
      state <= apb_idle;
    else if (!penable)
      state <= apb_setup;
    else
      state <= apb_access;
  end

  // Access phase only counts right after a setup phase
  assign access = psel && penable && (state == apb_setup);

  always_comb
  begin
    rd_data = '0;
    rd_hit  = 1'b1;
    wr_hit  = 1'b1;
    case (paddr)
      addr_ctrl:   rd_data = {29'd0, ctrl};
      addr_color:  rd_data = {26'd0, color};
      addr_limit:  rd_data = {22'd0, limit};
      addr_status:
      begin
        rd_data = {frame_count, 6'd0, offset};
        wr_hit  = 1'b0;   // Read only
      end
      default:
      begin
        rd_hit = 1'b0;
        wr_hit = 1'b0;
      end
    endcase
  end

  assign pready  = psel && penable;
  assign prdata  = (access && !pwrite) ? rd_data : '0;
  assign pslverr = access && (pwrite ? !wr_hit : !rd_hit);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      ctrl  <= ctrl_reset;
      color <= color_reset;
      limit <= limit_reset;
    end
    else if (access && pwrite)
    begin
      case (paddr)
        addr_ctrl:  ctrl  <= pwdata[2:0];
        addr_color: color <= pwdata[5:0];
        addr_limit: limit <= pwdata[9:0];
        default:    ;   // Status and holes are dropped
      endcase
    end
  end

  assign cfg.box_en       = ctrl[ctrl_box_bit];
  assign cfg.bmp_en       = ctrl[ctrl_bmp_bit];
  assign cfg.anim_en      = ctrl[ctrl_anim_bit];
  assign cfg.bmp_color    = color;
  assign cfg.offset_limit = limit;

endmodule

`default_nettype wire

// File: design/demoscene_top.sv
`timescale 1ns/1ps
`default_nettype none

module demoscene_top (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [3:0]  paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr,
  output logic        hsync,
  output logic        vsync,
  output logic [1:0]  red,
  output logic [1:0]  green,
  output logic [1:0]  blue
);

  logic        hsync_raw;
  logic        vsync_raw;
  logic        display_on;
  logic [9:0]  hpos;
  logic [9:0]  vpos;
  logic        frame_start;
  logic [31:0] row_bits;
  logic [9:0]  offset;
  logic [15:0] frame_count;
  logic        red_win;
  logic        green_win;
  logic        blue_win;

  demo_cfg_if cfg ();

  vga_timing i_vga_timing (
    .clk         (clk),
    .rst_n       (rst_n),
    .hsync       (hsync_raw),
    .vsync       (vsync_raw),
    .display_on  (display_on),
    .hpos        (hpos),
    .vpos        (vpos),
    .frame_start (frame_start)
  );

  // One logo row per 16 lines
  bitmap_rom i_bitmap_rom (
    .clk      (clk),
    .rst_n    (rst_n),
    .row_sel  (vpos[8:4]),
    .row_bits (row_bits)
  );

  box_animator i_box_animator (
    .clk         (clk),
    .rst_n       (rst_n),
    .cfg         (cfg.anim),
    .hpos        (hpos),
    .vpos        (vpos),
    .frame_start (frame_start),
    .offset      (offset),
    .frame_count (frame_count),
    .red_win     (red_win),
    .green_win   (green_win),
    .blue_win    (blue_win)
  );

  pixel_mixer i_pixel_mixer (
    .clk        (clk),
    .rst_n      (rst_n),
    .cfg        (cfg.mix),
    .hpos       (hpos),
    .vpos       (vpos),
    .display_on (display_on),
    .hsync_in   (hsync_raw),
    .vsync_in   (vsync_raw),
    .row_bits   (row_bits),
    .red_win    (red_win),
    .green_win  (green_win),
    .blue_win   (blue_win),
    .red        (red),
    .green      (green),
    .blue       (blue),
    .hsync      (hsync),
    .vsync      (vsync)
  );

  demo_regs i_demo_regs (
    .clk         (clk),
    .rst_n       (rst_n),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .paddr       (paddr),
    .pwdata      (pwdata),
    .prdata      (prdata),
    .pready      (pready),
    .pslverr     (pslverr),
    .cfg         (cfg.regs),
    .offset      (offset),
    .frame_count (frame_count)
  );

endmodule

`default_nettype wire

// File: design/pixel_mixer.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_mixer
  import demo_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  demo_cfg_if.mix     cfg,
  input  logic [9:0]  hpos,
  input  logic [9:0]  vpos,
  input  logic        display_on,
  input  logic        hsync_in,
  input  logic        vsync_in,
  input  logic [31:0] row_bits,
  input  logic        red_win,
  input  logic        green_win,
  input  logic        blue_win,
  output logic [1:0]  red,
  output logic [1:0]  green,
  output logic [1:0]  blue,
  output logic        hsync,
  output logic        vsync
);

  logic [9:0] hpos_d;
  logic [9:0] vpos_d;
  logic       display_d;
  logic       hsync_d;
  logic       vsync_d;
  logic [4:0] col;
  logic       logo_on;
  logic       box_on;
  logic [1:0] logo_r;
  logic [1:0] logo_g;
  logic [1:0] logo_b;

  // Align with the ROM row and the window flags
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      hpos_d    <= '0;
      vpos_d    <= '0;
      display_d <= 1'b0;
      hsync_d   <= 1'b1;
      vsync_d   <= 1'b1;
    end
    else
    begin
      hpos_d    <= hpos;
      vpos_d    <= vpos;
      display_d <= display_on;
      hsync_d   <= hsync_in;
      vsync_d   <= vsync_in;
    end
  end

  assign col     = hpos_d[8:4];   // 16 pixel cells
  assign logo_on = cfg.bmp_en && row_bits[5'd31 - col] &&
                   (hpos_d < 10'(bmp_x_limit)) && (vpos_d < 10'(bmp_y_limit));
  assign box_on  = display_d && cfg.box_en;

  assign logo_r = logo_on ? cfg.bmp_color[5:4] : 2'b00;
  assign logo_g = logo_on ? cfg.bmp_color[3:2] : 2'b00;
  assign logo_b = logo_on ? cfg.bmp_color[1:0] : 2'b00;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      red   <= '0;
      green <= '0;
      blue  <= '0;
      hsync <= 1'b1;
      vsync <= 1'b1;
    end
    else
    begin
      red   <= display_d ? ({2{box_on && red_win}} ^ logo_r) : 2'b00;
      green <= display_d ? ({2{box_on && green_win}} ^ logo_g) : 2'b00;
      blue  <= display_d ? ({2{box_on && blue_win}} ^ logo_b) : 2'b00;
      hsync <= hsync_d;
      vsync <= vsync_d;
    end
  end

endmodule

`default_nettype wire

// File: design/vga_timing.sv
`timescale 1ns/1ps
`default_nettype none

module vga_timing
  import demo_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  output logic       hsync,
  output logic       vsync,
  output logic       display_on,
  output logic [9:0] hpos,
  output logic [9:0] vpos,
  output logic       frame_start
);

  logic h_last;
  logic v_last;

  assign h_last = (hpos == 10'(h_total - 1));
  assign v_last = (vpos == 10'(v_total - 1));

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      hpos <= '0;
      vpos <= '0;
    end
    else if (h_last)
    begin
      hpos <= '0;
      if (v_last)
        vpos <= '0;
      else
        vpos <= vpos + 10'd1;
    end
    else
    begin
      hpos <= hpos + 10'd1;
    end
  end

  // Sync pulses are active low
  assign hsync = !((hpos >= 10'(h_visible + h_front)) &&
                   (hpos <  10'(h_visible + h_front + h_sync)));
  assign vsync = !((vpos >= 10'(v_visible + v_front)) &&
                   (vpos <  10'(v_visible + v_front + v_sync)));

  assign display_on  = (hpos < 10'(h_visible)) && (vpos < 10'(v_visible));
  assign frame_start = (hpos == '0) && (vpos == '0);  // First pixel of a frame

endmodule

`default_nettype wire

// File: sim/demoscene_tb.sv
`timescale 1ns/1ps
`default_nettype none

module demoscene_tb
  import demo_pkg::*;
();

  logic        clk;
  logic        rst_n;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [3:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  logic        hsync;
  logic        vsync;
  logic [1:0]  red;
  logic [1:0]  green;
  logic [1:0]  blue;

  int          checks = 0;
  int          errors = 0;
  int          timeouts = 0;
  int          seed = 99;
  int          low;
  int          high;
  int          px;
  logic [31:0] data;
  logic [31:0] stat0;
  logic [31:0] stat1;
  logic        err;
  logic [5:0]  seen;

  tb_clkgen i_tb_clkgen (.clk(clk));

  demoscene_top i_demoscene_top (
    .clk     (clk),
    .rst_n   (rst_n),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .hsync   (hsync),
    .vsync   (vsync),
    .red     (red),
    .green   (green),
    .blue    (blue)
  );

  task automatic finish_run();
    $display("checks %0d errors %0d timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  endtask

  task automatic report_timeout(input string what);
    timeouts++;
    $display("timeout while waiting for %s", what);
    finish_run();
  endtask

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (act === exp)
    else
    begin
      errors++;
      $display("error %s expected %h actual %h", name, exp, act);
    end
  endtask

  // One APB transfer, setup then access until pready
  task automatic apb_transfer(input logic write, input logic [3:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic slverr);
    int n;
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= write;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge clk);
    penable <= 1'b1;
    n = 0;
    do
    begin
      @(posedge clk);
      n++;
    end
    while (!pready && n < 16);
    if (!pready)
      report_timeout("pready");
    check_value("pready in first access cycle", 32'd1, n);
    rdata   = prdata;
    slverr  = pslverr;
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  task automatic write_expect(input string name, input logic [3:0] addr,
                              input logic [31:0] wdata, input logic exp_err);
    logic [31:0] rdata;
    logic        slverr;
    apb_transfer(1'b1, addr, wdata, rdata, slverr);
    check_value({name, " pslverr"}, exp_err, slverr);
  endtask

  task automatic read_expect(input string name, input logic [3:0] addr,
                             input logic [31:0] exp, input logic exp_err);
    logic [31:0] rdata;
    logic        slverr;
    apb_transfer(1'b0, addr, 32'd0, rdata, slverr);
    check_value({name, " data"}, exp, rdata);
    check_value({name, " pslverr"}, exp_err, slverr);
  endtask

  // Returns on the first sample that shows the new level
  task automatic wait_sync_edge(input bit vert, input logic level, input int limit);
    logic prev;
    logic cur;
    int   n;
    cur = vert ? vsync : hsync;
    n = 0;
    do
    begin
      prev = cur;
      @(posedge clk);
      cur = vert ? vsync : hsync;
      n++;
    end
    while (!(prev != level && cur == level) && n < limit);
    if (!(prev != level && cur == level))
      report_timeout(vert ? "vsync edge" : "hsync edge");
  endtask

  task automatic count_level(input bit vert, input logic level, input int limit,
                             output int n);
    logic cur;
    n = 0;
    cur = level;
    while (cur == level && n < limit)
    begin
      @(posedge clk);
      n++;
      cur = vert ? vsync : hsync;
    end
    if (cur == level)
      report_timeout(vert ? "vsync change" : "hsync change");
  endtask

  task automatic skip_cycles(input int n);
    repeat (n) @(posedge clk);
  endtask

  initial
  begin
    rst_n   = 1'b0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;

    // Register reset values, read back, error responses
    read_expect("ctrl reset", addr_ctrl, 32'(ctrl_reset), 1'b0);
    read_expect("color reset", addr_color, 32'(color_reset), 1'b0);
    read_expect("limit reset", addr_limit, 32'(limit_reset), 1'b0);
    data = $random(seed);
    write_expect("color write", addr_color, data, 1'b0);
    read_expect("color readback", addr_color, {26'd0, data[5:0]}, 1'b0);
    data = $random(seed);
    write_expect("limit write", addr_limit, data, 1'b0);
    read_expect("limit readback", addr_limit, {22'd0, data[9:0]}, 1'b0);
    write_expect("limit restore", addr_limit, 32'(limit_reset), 1'b0);
    write_expect("status write", addr_status, data, 1'b1);
    write_expect("unmapped write", 4'h6, data, 1'b1);
    read_expect("unmapped read", 4'h2, 32'd0, 1'b1);

    // Sync widths and periods
    wait_sync_edge(1'b0, 1'b0, 2 * h_total);
    count_level(1'b0, 1'b0, h_total, low);
    count_level(1'b0, 1'b1, h_total, high);
    check_value("hsync low", h_sync, low);
    check_value("hsync period", h_total, low + high);
    wait_sync_edge(1'b1, 1'b0, 2 * v_total * h_total);
    count_level(1'b1, 1'b0, v_total * h_total, low);
    count_level(1'b1, 1'b1, v_total * h_total, high);
    check_value("vsync low", v_sync * h_total, low);
    check_value("vsync period", v_total * h_total, low + high);

    // Right border blanking on the first visible lines
    wait_sync_edge(1'b1, 1'b1, 2 * v_total * h_total);
    skip_cycles(v_back * h_total);   // Pixel 0 of line 0
    repeat (4)
    begin
      wait_sync_edge(1'b0, 1'b0, 2 * h_total);
      skip_cycles(h_total - h_front);   // Pixel 640 of next line
      seen = '0;
      for (px = h_visible; px < h_total; px++)
      begin
        seen = seen | {red, green, blue};
        if (px < h_total - 1)
          @(posedge clk);
      end
      check_value("blanking", 32'd0, seen);
    end

    // Logo only, row 0 starts dark, dark, lit
    write_expect("ctrl logo", addr_ctrl, (1 << ctrl_bmp_bit) | (1 << ctrl_anim_bit), 1'b0);
    write_expect("color known", addr_color, 32'h27, 1'b0);
    wait_sync_edge(1'b1, 1'b1, 2 * v_total * h_total);
    skip_cycles(v_back * h_total);
    for (px = 0; px < 48; px++)
    begin
      check_value($sformatf("logo pixel %0d", px), (px < 32) ? 32'd0 : 32'h27,
                  {red, green, blue});
      if (px < 47)
        @(posedge clk);
    end

    // Offset follows the frame count while animating
    wait_sync_edge(1'b1, 1'b0, 2 * v_total * h_total);   // Away from frame start
    apb_transfer(1'b0, addr_status, 32'd0, stat0, err);
    check_value("status pslverr", 1'b0, err);
    check_value("offset from reset", stat0[25:16], stat0[9:0]);
    wait_sync_edge(1'b1, 1'b0, 2 * v_total * h_total);
    apb_transfer(1'b0, addr_status, 32'd0, stat1, err);
    check_value("frame step", stat0[31:16] + 1, stat1[31:16]);
    check_value("offset step", stat0[9:0] + 1, stat1[9:0]);

    // Frozen animation
    write_expect("ctrl freeze", addr_ctrl, (1 << ctrl_box_bit) | (1 << ctrl_bmp_bit), 1'b0);
    apb_transfer(1'b0, addr_status, 32'd0, stat0, err);
    wait_sync_edge(1'b1, 1'b0, 2 * v_total * h_total);
    wait_sync_edge(1'b1, 1'b0, 2 * v_total * h_total);
    apb_transfer(1'b0, addr_status, 32'd0, stat1, err);
    check_value("frozen frames", stat0[31:16] + 2, stat1[31:16]);
    check_value("frozen offset", stat0[9:0], stat1[9:0]);

    finish_run();
  end

endmodule

`default_nettype wire

// File: sim/tb_clkgen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
  output logic clk
);

  localparam int half_period = 50;   // 100 ns period

  initial
  begin
    clk = 1'b0;
    forever
      #half_period clk = ~clk;
  end

endmodule

`default_nettype wire
